// ==== verilog/sdPkg.sv ====
package sdPkg;

    // ========================================
    // Command indices
    // ========================================
    typedef enum logic [5:0] {
        goIdle       = 6'd0,
        allSendCid   = 6'd2,
        sendRelAddr  = 6'd3,
        sendIfCond   = 6'd8,
        sdSendOpCond = 6'd41,
        appCmd       = 6'd55
    } sdCmdCode;

    // ========================================
    // Command frame, sent MSB first
    // ========================================
    typedef struct packed {
        logic       startBit;
        logic       transBit;
        logic [5:0] index;
        logic [31:0] arg;
        logic [6:0] crc;
        logic       endBit;
    } sdFrame;

    // ========================================
    // State machines
    // ========================================
    typedef enum logic [2:0] {
        holdOff,
        powerWait,
        pulseHigh,
        pulseLow,
        ready
    } seqState;

    typedef enum logic [1:0] {
        idle,
        shifting,
        finish
    } txState;

endpackage

// ==== verilog/sdLineIf.sv ====
interface sdLineIf;

    // One driver's view of the card bus
    logic       sdClk;
    logic       cmdOut;
    logic       cmdOutEn;
    logic [3:0] datOut;
    logic [3:0] datOutEn;

    modport source (
        output sdClk, cmdOut, cmdOutEn, datOut, datOutEn
    );

    modport sink (
        input sdClk, cmdOut, cmdOutEn, datOut, datOutEn
    );

endinterface

// ==== verilog/powerSequencer.sv ====
module powerSequencer import sdPkg::*; #(
    // Defaults assume a 48 MHz system clock
    parameter int unsigned PowerOffTicks  = 48000000,
    parameter int unsigned PowerOnTicks   = 2400000,
    parameter int unsigned PulseHighTicks = 1440,
    parameter int unsigned PulseLowTicks  = 480
) (
    input  logic clk,
    input  logic arstN,
    input  logic pwrReq,
    output logic pwrAck,
    output logic pwrEn,
    output logic busReady,
    sdLineIf.source lines
);

    seqState     state;
    logic [31:0] tickCnt;
    logic        cycleActive;
    logic        pwrReqD;
    logic        pwrReqRise;

    assign pwrReqRise = pwrReq && !pwrReqD;

    // ========================================
    // Sequence FSM
    // ========================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state       <= holdOff;
            tickCnt     <= '0;
            cycleActive <= 1'b0;
            pwrReqD     <= 1'b0;
            pwrEn       <= 1'b0;
            pwrAck      <= 1'b0;
        end else begin
            pwrReqD <= pwrReq;
            // Delayed one cycle to line up with the pin register
            pwrEn   <= (state != holdOff);
            // Held off on the request edge itself so a new cycle never acks early
            pwrAck  <= (state == ready) && pwrReq && pwrReqD;

            if (pwrReqRise) begin
                // Always restart from power off
                state       <= holdOff;
                tickCnt     <= 32'(PowerOffTicks - 1);
                cycleActive <= 1'b1;
            end else if (tickCnt != '0) begin
                tickCnt <= tickCnt - 32'd1;
            end else begin
                case (state)
                    holdOff: begin
                        if (cycleActive) begin
                            state       <= powerWait;
                            tickCnt     <= 32'(PowerOnTicks - 1);
                            cycleActive <= 1'b0;
                        end
                    end
                    powerWait: begin
                        // Identification pulse
                        state   <= pulseHigh;
                        tickCnt <= 32'(PulseHighTicks - 1);
                    end
                    pulseHigh: begin
                        state   <= pulseLow;
                        tickCnt <= 32'(PulseLowTicks - 1);
                    end
                    pulseLow: begin
                        state <= ready;
                    end
                    ready: begin
                        state <= ready;
                    end
                    default: begin
                        state <= holdOff;
                    end
                endcase
            end
        end
    end

    // ========================================
    // Bus lines
    // ========================================
    // Everything held low until the sequence is done, then released
    assign lines.sdClk    = (state == pulseHigh);
    assign lines.cmdOut   = 1'b0;
    assign lines.cmdOutEn = (state != ready);
    assign lines.datOut   = 4'b0000;
    assign lines.datOutEn = {4{state != ready}};

    assign busReady = (state == ready);

endmodule

// ==== verilog/cmdTransmitter.sv ====
module cmdTransmitter import sdPkg::*; #(
    // System cycles per card clock half period
    parameter int unsigned ClkDiv = 60
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        cmdReq,
    output logic        cmdAck,
    input  sdCmdCode    cmdIndex,
    input  logic [31:0] cmdArg,
    input  logic        busReady,
    sdLineIf.source     lines
);

    localparam int DivW = $clog2(ClkDiv + 1);

    txState            state;
    logic [DivW-1:0]   divCnt;
    logic              clkPhase;
    logic [5:0]        bitCnt;
    logic [47:0]       shiftReg;
    sdFrame            frameNext;
    logic              loadFrame;
    logic              fallEdge;

    // CRC7, polynomial x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7(input logic [39:0] data);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb     = data[i] ^ crc[6];
            crc    = {crc[5:0], 1'b0};
            crc[0] = fb;
            crc[3] = crc[3] ^ fb;
        end
        return crc;
    endfunction

    // ========================================
    // Frame assembly
    // ========================================
    always_comb begin
        frameNext.startBit = 1'b0;
        frameNext.transBit = 1'b1;
        frameNext.index    = cmdIndex;
        frameNext.arg      = cmdArg;
        frameNext.crc      = crc7({2'b01, cmdIndex, cmdArg});
        frameNext.endBit   = 1'b1;
    end

    assign loadFrame = (state == idle) && cmdReq && busReady;
    // High half just ended
    assign fallEdge  = (state == shifting) && (divCnt == '0) && clkPhase;

    // ========================================
    // Control FSM
    // ========================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= idle;
            cmdAck   <= 1'b0;
            divCnt   <= '0;
            clkPhase <= 1'b0;
            bitCnt   <= '0;
        end else begin
            case (state)
                idle: begin
                    if (loadFrame) begin
                        state    <= shifting;
                        clkPhase <= 1'b0;
                        divCnt   <= DivW'(ClkDiv - 1);
                        bitCnt   <= 6'd47;
                    end
                end
                shifting: begin
                    if (divCnt != '0) begin
                        divCnt <= divCnt - 1'b1;
                    end else begin
                        divCnt   <= DivW'(ClkDiv - 1);
                        clkPhase <= ~clkPhase;
                        if (clkPhase) begin
                            if (bitCnt == 6'd0) begin
                                // End bit has been clocked out
                                state  <= finish;
                                cmdAck <= 1'b1;
                            end else begin
                                bitCnt <= bitCnt - 6'd1;
                            end
                        end
                    end
                end
                finish: begin
                    if (!cmdReq) begin
                        state  <= idle;
                        cmdAck <= 1'b0;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Payload shift register
    always_ff @(posedge clk) begin
        if (loadFrame) begin
            shiftReg <= frameNext;
        end else if (fallEdge) begin
            shiftReg <= {shiftReg[46:0], 1'b1};
        end
    end

    // ========================================
    // Bus lines
    // ========================================
    assign lines.sdClk    = (state == shifting) && clkPhase;
    assign lines.cmdOut   = shiftReg[47];
    assign lines.cmdOutEn = (state == shifting);
    // Command path only, dat stays with the sequencer
    assign lines.datOut   = 4'b0000;
    assign lines.datOutEn = 4'b0000;

endmodule

// ==== verilog/sdBusArbiter.sv ====
module sdBusArbiter (
    input  logic       clk,
    input  logic       arstN,
    sdLineIf.sink      seqLines,
    sdLineIf.sink      txLines,
    output logic       sdClk,
    output logic       sdCmdOut,
    output logic       sdCmdOutEn,
    output logic [3:0] sdDatOut,
    output logic [3:0] sdDatOutEn,
    input  logic [3:0] sdDatIn,
    output logic       cardPresent
);

    logic detSync;

    // ========================================
    // Pin output register
    // ========================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            // Bus held low until the sequencer says otherwise
            sdClk      <= 1'b0;
            sdCmdOut   <= 1'b0;
            sdCmdOutEn <= 1'b1;
            sdDatOut   <= 4'b0000;
            sdDatOutEn <= 4'b1111;
        end else begin
            sdClk      <= seqLines.sdClk | txLines.sdClk;
            sdCmdOutEn <= seqLines.cmdOutEn | txLines.cmdOutEn;
            sdCmdOut   <= txLines.cmdOutEn ? txLines.cmdOut : seqLines.cmdOut;
            sdDatOutEn <= seqLines.datOutEn | txLines.datOutEn;
            // Per bit, the transmitter wins where it drives
            sdDatOut   <= (txLines.datOutEn & txLines.datOut)
                        | (~txLines.datOutEn & seqLines.datOut);
        end
    end

    // ========================================
    // Card detect on DAT3
    // ========================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            detSync     <= 1'b0;
            cardPresent <= 1'b0;
        end else begin
            detSync     <= sdDatIn[3];
            cardPresent <= detSync;
        end
    end

endmodule

// ==== verilog/sdBringupTop.sv ====
module sdBringupTop import sdPkg::*; #(
    parameter int unsigned PowerOffTicks  = 48000000,
    parameter int unsigned PowerOnTicks   = 2400000,
    parameter int unsigned PulseHighTicks = 1440,
    parameter int unsigned PulseLowTicks  = 480,
    parameter int unsigned ClkDiv         = 60
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        pwrReq,
    output logic        pwrAck,
    input  logic        cmdReq,
    output logic        cmdAck,
    input  sdCmdCode    cmdIndex,
    input  logic [31:0] cmdArg,
    output logic        sdPwrEn,
    output logic        sdClk,
    output logic        sdCmdOut,
    output logic        sdCmdOutEn,
    output logic [3:0]  sdDatOut,
    output logic [3:0]  sdDatOutEn,
    input  logic [3:0]  sdDatIn,
    output logic        cardPresent
);

    logic busReady;

    sdLineIf seqLines ();
    sdLineIf txLines ();

    // Power-up sequence, drives sdPwrEn from its own register
    powerSequencer #(
        .PowerOffTicks  (PowerOffTicks),
        .PowerOnTicks   (PowerOnTicks),
        .PulseHighTicks (PulseHighTicks),
        .PulseLowTicks  (PulseLowTicks)
    ) u_powerSequencer (
        .clk      (clk),
        .arstN    (arstN),
        .pwrReq   (pwrReq),
        .pwrAck   (pwrAck),
        .pwrEn    (sdPwrEn),
        .busReady (busReady),
        .lines    (seqLines.source)
    );

    cmdTransmitter #(
        .ClkDiv (ClkDiv)
    ) u_cmdTransmitter (
        .clk      (clk),
        .arstN    (arstN),
        .cmdReq   (cmdReq),
        .cmdAck   (cmdAck),
        .cmdIndex (cmdIndex),
        .cmdArg   (cmdArg),
        .busReady (busReady),
        .lines    (txLines.source)
    );

    sdBusArbiter u_sdBusArbiter (
        .clk         (clk),
        .arstN       (arstN),
        .seqLines    (seqLines.sink),
        .txLines     (txLines.sink),
        .sdClk       (sdClk),
        .sdCmdOut    (sdCmdOut),
        .sdCmdOutEn  (sdCmdOutEn),
        .sdDatOut    (sdDatOut),
        .sdDatOutEn  (sdDatOutEn),
        .sdDatIn     (sdDatIn),
        .cardPresent (cardPresent)
    );

endmodule

// ==== testbench/sdBringupTb.sv ====
module sdBringupTb import sdPkg::*; ();

    localparam int PowerOffTicks  = 20;
    localparam int PowerOnTicks   = 30;
    localparam int PulseHighTicks = 6;
    localparam int PulseLowTicks  = 4;
    localparam int ClkDiv         = 2;
    localparam int NumCmds        = 40;
    localparam int ExtraCmds      = 4;
    localparam int DetectCycles   = 40;

    // Worst-case lengths in system cycles
    localparam int PwrLen     = PowerOffTicks + PowerOnTicks + PulseHighTicks + PulseLowTicks + 8;
    localparam int CmdLen     = 2 * ClkDiv * 48 + 8;
    localparam int CycleLimit = 16 + 2 * PwrLen + (NumCmds + ExtraCmds + 2) * CmdLen
                              + DetectCycles + 200;

    logic        clk;
    logic        arstN;
    logic        pwrReq;
    logic        pwrAck;
    logic        cmdReq;
    logic        cmdAck;
    sdCmdCode    cmdIndex;
    logic [31:0] cmdArg;
    logic        sdPwrEn;
    logic        sdClk;
    logic        sdCmdOut;
    logic        sdCmdOutEn;
    logic [3:0]  sdDatOut;
    logic [3:0]  sdDatOutEn;
    logic [3:0]  sdDatIn;
    logic        cardPresent;

    // Card side of the bus
    logic [3:0]  cardDat;
    logic        cmdPin;
    logic [3:0]  datPin;

    logic        prevSdClk = 1'b0;
    logic        prevPwrReq = 1'b0;
    logic        prevCmdReq = 1'b0;
    logic        bitQ[$];
    logic        detHist[DetectCycles];
    sdFrame      expFrame;
    int          cycleCount = 0;
    int          bitErrs = 0;
    int          frameErrs = 0;
    int          tickErrs = 0;
    int          otherErrs = 0;

    // Pull-up on cmd when nobody drives it
    // Card drives dat once the bus is released
    assign cmdPin  = sdCmdOutEn ? sdCmdOut : 1'b1;
    assign datPin  = (sdDatOutEn & sdDatOut) | (~sdDatOutEn & cardDat);
    assign sdDatIn = datPin;

    sdBringupTop #(
        .PowerOffTicks  (PowerOffTicks),
        .PowerOnTicks   (PowerOnTicks),
        .PulseHighTicks (PulseHighTicks),
        .PulseLowTicks  (PulseLowTicks),
        .ClkDiv         (ClkDiv)
    ) u_dut (
        .clk         (clk),
        .arstN       (arstN),
        .pwrReq      (pwrReq),
        .pwrAck      (pwrAck),
        .cmdReq      (cmdReq),
        .cmdAck      (cmdAck),
        .cmdIndex    (cmdIndex),
        .cmdArg      (cmdArg),
        .sdPwrEn     (sdPwrEn),
        .sdClk       (sdClk),
        .sdCmdOut    (sdCmdOut),
        .sdCmdOutEn  (sdCmdOutEn),
        .sdDatOut    (sdDatOut),
        .sdDatOutEn  (sdDatOutEn),
        .sdDatIn     (sdDatIn),
        .cardPresent (cardPresent)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // ========================================
    // Reference model
    // ========================================
    function automatic logic [6:0] modelCrc(input logic [39:0] bits);
        logic [6:0] acc;
        logic       inv;
        acc = 7'h00;
        for (int i = 39; i >= 0; i--) begin
            inv = bits[i] ^ acc[6];
            acc = (acc << 1) ^ (inv ? 7'h09 : 7'h00);
        end
        return acc;
    endfunction

    function automatic sdFrame modelFrame(input sdCmdCode idx, input logic [31:0] arg);
        sdFrame f;
        f.startBit = 1'b0;
        f.transBit = 1'b1;
        f.index    = idx;
        f.arg      = arg;
        f.crc      = modelCrc({1'b0, 1'b1, idx, arg});
        f.endBit   = 1'b1;
        return f;
    endfunction

    function automatic sdCmdCode pickCode(input int unsigned r);
        case (r % 6)
            0: return goIdle;
            1: return allSendCid;
            2: return sendRelAddr;
            3: return sendIfCond;
            4: return sdSendOpCond;
            default: return appCmd;
        endcase
    endfunction

    // ========================================
    // Compare tasks
    // ========================================
    task automatic checkBit(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("Error at %0t: %s expected %b, got %b", $time, name, expVal, actVal);
            bitErrs++;
        end
    endtask

    // Per-bit compare of a 4-bit pin group
    task automatic checkEachBit(input string name, input logic [3:0] expVal,
                                input logic [3:0] actVal);
        for (int i = 0; i < 4; i++) begin
            checkBit($sformatf("%s[%0d]", name, i), expVal[i], actVal[i]);
        end
    endtask

    task automatic checkFrame(input sdFrame expVal, input sdFrame actVal);
        if (actVal !== expVal) begin
            $display("Error at %0t: command frame expected %h, got %h",
                     $time, expVal, actVal);
            frameErrs++;
        end
    endtask

    task automatic checkTicks(input string name, input int expVal, input int actVal);
        if (actVal != expVal) begin
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, expVal, actVal);
            tickErrs++;
        end
    endtask

    // ========================================
    // Pin monitor
    // ========================================
    // Frame bits are taken at rising card clock while dat is released
    always @(posedge clk) begin
        if (arstN) begin
            if (sdClk && !prevSdClk && sdDatOutEn == 4'b0000) begin
                bitQ.push_back(cmdPin);
                checkBit("sdCmdOutEn", 1'b1, sdCmdOutEn);
            end
            if (pwrAck && !prevPwrReq) begin
                $display("pwrAck was high at %0t without a pending pwrReq", $time);
                otherErrs++;
            end
            if (cmdAck && !prevCmdReq) begin
                $display("cmdAck was high at %0t without a pending cmdReq", $time);
                otherErrs++;
            end
        end
        prevSdClk  = sdClk;
        prevPwrReq = pwrReq;
        prevCmdReq = cmdReq;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CycleLimit) begin
            $display("Timeout, the run was still busy after %0d cycles", CycleLimit);
            $display("Done: errors found");
            $finish;
        end
    end

    // ========================================
    // Stimulus tasks
    // ========================================
    task automatic raiseCmd();
        cmdIndex = pickCode($urandom);
        cmdArg   = $urandom;
        cmdReq   = 1'b1;
        expFrame = modelFrame(cmdIndex, cmdArg);
        bitQ.delete();
    endtask

    task automatic finishCmd();
        sdFrame got;
        int     waitCnt;
        waitCnt = 0;
        while (!cmdAck && waitCnt < CmdLen + PwrLen) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!cmdAck) begin
            $display("cmdAck never rose for command index %0d", expFrame.index);
            otherErrs++;
        end else begin
            checkTicks("sdClk rises per frame", 48, bitQ.size());
            if (bitQ.size() == 48) begin
                for (int i = 0; i < 48; i++) begin
                    got[47 - i] = bitQ[i];
                end
                checkFrame(expFrame, got);
            end
            // Ack has to stay up while the request is held
            @(negedge clk);
            checkBit("cmdAck", 1'b1, cmdAck);
        end
        cmdReq = 1'b0;
        @(negedge clk);
        checkBit("cmdAck", 1'b0, cmdAck);
        checkBit("sdCmdOutEn", 1'b0, sdCmdOutEn);
        checkBit("sdClk", 1'b0, sdClk);
        checkEachBit("sdDatOutEn", 4'b0000, sdDatOutEn);
    endtask

    // One cycle while the bus is still owned by the sequencer
    task automatic advanceHeld();
        if (cmdAck || bitQ.size() != 0) begin
            $display("Command ran at %0t before pwrAck rose", $time);
            otherErrs++;
        end
        checkBit("pwrAck", 1'b0, pwrAck);
        @(negedge clk);
    endtask

    task automatic powerCycle(input bit withCmd);
        int cnt;
        pwrReq = 1'b1;
        bitQ.delete();
        @(negedge clk);
        // Command raised after the request edge has been taken
        if (withCmd) begin
            raiseCmd();
        end
        @(negedge clk);
        cnt = 0;
        while (!sdPwrEn && cnt < PwrLen) begin
            cnt++;
            advanceHeld();
        end
        checkTicks("sdPwrEn low", PowerOffTicks, cnt);
        cnt = 0;
        while (!sdClk && cnt < PwrLen) begin
            cnt++;
            advanceHeld();
        end
        checkTicks("sdPwrEn high before pulse", PowerOnTicks, cnt);
        checkBit("sdPwrEn", 1'b1, sdPwrEn);
        cnt = 0;
        while (sdClk && cnt < PwrLen) begin
            cnt++;
            advanceHeld();
        end
        checkTicks("sdClk pulse high", PulseHighTicks, cnt);
        cnt = 0;
        while (!sdClk && sdCmdOutEn && cnt < PwrLen) begin
            cnt++;
            advanceHeld();
        end
        checkTicks("sdClk pulse low", PulseLowTicks, cnt);
        // Lines released and acked in the same cycle
        checkBit("pwrAck", 1'b1, pwrAck);
        checkBit("sdCmdOutEn", 1'b0, sdCmdOutEn);
        checkEachBit("sdDatOutEn", 4'b0000, sdDatOutEn);
        @(negedge clk);
        checkBit("pwrAck", 1'b1, pwrAck);
        pwrReq = 1'b0;
        @(negedge clk);
        checkBit("pwrAck", 1'b0, pwrAck);
        if (withCmd) begin
            finishCmd();
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        void'($urandom(50));
        arstN    = 1'b0;
        pwrReq   = 1'b0;
        cmdReq   = 1'b0;
        cmdIndex = goIdle;
        cmdArg   = '0;
        cardDat  = 4'b0000;
        repeat (16) @(negedge clk);

        // Bus held low, power off
        checkBit("sdPwrEn", 1'b0, sdPwrEn);
        checkBit("sdClk", 1'b0, sdClk);
        checkBit("sdCmdOutEn", 1'b1, sdCmdOutEn);
        checkBit("sdCmdOut", 1'b0, sdCmdOut);
        checkEachBit("sdDatOutEn", 4'b1111, sdDatOutEn);
        checkEachBit("sdDatOut", 4'b0000, sdDatOut);
        checkBit("pwrAck", 1'b0, pwrAck);
        checkBit("cmdAck", 1'b0, cmdAck);
        checkBit("cardPresent", 1'b0, cardPresent);
        arstN = 1'b1;
        @(negedge clk);

        powerCycle(1'b1);
        repeat (NumCmds) begin
            raiseCmd();
            finishCmd();
        end

        // Second power-up with a command waiting on it
        powerCycle(1'b1);
        repeat (ExtraCmds) begin
            raiseCmd();
            finishCmd();
        end

        // Card detect on DAT3 with random levels on the other dat bits
        for (int i = 0; i < DetectCycles; i++) begin
            if (i >= 2) begin
                checkBit("cardPresent", detHist[i - 2], cardPresent);
            end
            cardDat    = 4'($urandom);
            detHist[i] = cardDat[3];
            @(negedge clk);
        end

        $display("Error counts: bit %0d, frame %0d, ticks %0d, other %0d",
                 bitErrs, frameErrs, tickErrs, otherErrs);
        if (bitErrs + frameErrs + tickErrs + otherErrs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== sdBringupTop.f ====
verilog/sdPkg.sv
verilog/sdLineIf.sv
verilog/powerSequencer.sv
verilog/cmdTransmitter.sv
verilog/sdBusArbiter.sv
verilog/sdBringupTop.sv
testbench/sdBringupTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
verilator --binary --timing -Wno-fatal -f sdBringupTop.f --top-module sdBringupTb -o simv \
    && ./obj_dir/simv > sim.log \
    && grep -qx "Done: no errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
